// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
LINT     = --lint-only --timing --assert
TOP      = ooo_core_tb
RTL_TOP  = ooo_core
FILELIST = project.f
BUILD    = obj_dir
LOG      = sim.log
PASS     = sim passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS)$$" $(LOG)

lint:
	$(TOOL) $(LINT) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== hdl/arith_unit.sv ====
`default_nettype none

module arith_unit (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               arith_go,
  input  ooo_pkg::dispatch_t dispatch,
  output logic               arith_done,
  output ooo_pkg::complete_t arith_result
);
  import ooo_pkg::*;

  word_t result;

  // addi shares the add path, b already holds the immediate
  always_comb begin
    case (dispatch.op)
      OP_ADD, OP_ADDI: result = dispatch.a + dispatch.b;
      OP_SUB:          result = dispatch.a - dispatch.b;
      OP_AND:          result = dispatch.a & dispatch.b;
      OP_OR:           result = dispatch.a | dispatch.b;
      OP_XOR:          result = dispatch.a ^ dispatch.b;
      // upper immediate, low half cleared
      OP_LUI:          result = dispatch.b << 16;
      default:         result = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arith_done <= 1'b0;
    end else begin
      arith_done <= arith_go;
    end
  end

  always_ff @(posedge clk) begin
    if (arith_go) begin
      arith_result.tag    <= dispatch.tag;
      arith_result.result <= result;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/completion_buffer.sv ====
`default_nettype none

`include "ooo_defs.svh"

module completion_buffer (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               alloc,
  input  ooo_pkg::reg_idx_t  alloc_rd,
  input  logic               alloc_wen,
  input  logic               alloc_illegal,
  input  logic               arith_done,
  input  ooo_pkg::complete_t arith_result,
  input  logic               div_done,
  input  ooo_pkg::complete_t div_result,
  input  logic               commit_ready,
  output ooo_pkg::tag_t      alloc_tag,
  output logic               cb_full,
  output logic               commit_valid,
  output ooo_pkg::commit_t   commit,
  output logic               retire_valid,
  output ooo_pkg::reg_idx_t  retire_rd,
  output ooo_pkg::word_t     retire_data
);
  import ooo_pkg::*;

  commit_t                  entry [`OOO_CB_DEPTH];
  logic [`OOO_CB_DEPTH-1:0] valid;
  logic [`OOO_CB_DEPTH-1:0] done;
  // oldest entry
  tag_t                     head;
  // next free slot, also the tag handed to issue
  tag_t                     tail;
  logic                     commit_fire;

  assign alloc_tag = tail;
  // tail ran into a live entry
  assign cb_full   = valid[tail];

  // in order, only the head may leave
  assign commit       = entry[head];
  assign commit_valid = valid[head] & done[head];
  assign commit_fire  = commit_valid & commit_ready;

  // exceptions and non-writing ops leave the register file alone
  assign retire_valid = commit_fire & commit.wen & ~commit.exc;
  assign retire_rd    = commit.rd;
  assign retire_data  = commit.data;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      valid <= '0;
      done  <= '0;
    end else begin
      // two write ports, tags always differ
      if (arith_done) begin
        done[arith_result.tag] <= 1'b1;
      end
      if (div_done) begin
        done[div_result.tag] <= 1'b1;
      end
      if (commit_fire) begin
        valid[head] <= 1'b0;
        done[head]  <= 1'b0;
        head        <= head + 1'b1;
      end
      // illegal ops have nothing to execute and are done at once
      if (alloc) begin
        valid[tail] <= 1'b1;
        done[tail]  <= alloc_illegal;
        tail        <= tail + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alloc) begin
      entry[tail].rd   <= alloc_rd;
      entry[tail].wen  <= alloc_wen;
      entry[tail].exc  <= alloc_illegal;
      entry[tail].data <= '0;
    end
    if (arith_done) begin
      entry[arith_result.tag].data <= arith_result.result;
    end
    if (div_done) begin
      entry[div_result.tag].data <= div_result.result;
    end
  end

  a_arith_tag_live: assert property (@(posedge clk) disable iff (!rst_n)
    arith_done |-> valid[arith_result.tag] && !done[arith_result.tag])
    else $error("alu completion for a free or finished entry");

  a_div_tag_live: assert property (@(posedge clk) disable iff (!rst_n)
    div_done |-> valid[div_result.tag] && !done[div_result.tag])
    else $error("divider completion for a free or finished entry");

  a_no_alloc_full: assert property (@(posedge clk) disable iff (!rst_n)
    alloc |-> !cb_full)
    else $error("allocation into a full buffer");

endmodule

`default_nettype wire

// ==== hdl/div_unit.sv ====
`default_nettype none

`include "ooo_defs.svh"

module div_unit (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               div_go,
  input  ooo_pkg::dispatch_t dispatch,
  output logic               div_busy,
  output logic               div_done,
  output ooo_pkg::complete_t div_result
);
  import ooo_pkg::*;

  localparam int CNT_W = $clog2(`OOO_DIV_STEPS + 1);

  // steps left, zero when idle
  logic [CNT_W-1:0] count;
  // dividend shifts out of quot as quotient bits shift in
  word_t            quot;
  word_t            rem;
  word_t            divisor;
  logic             want_rem;
  tag_t             tag;
  logic [`OOO_XLEN:0] trial;
  logic             fits;
  word_t            rem_next;
  word_t            quot_next;

  // one restoring step
  // a zero divisor always fits, giving all ones and rem equal to the dividend
  always_comb begin
    trial     = {rem, quot[`OOO_XLEN-1]};
    fits      = (trial >= {1'b0, divisor});
    rem_next  = fits ? word_t'(trial - {1'b0, divisor}) : trial[`OOO_XLEN-1:0];
    quot_next = {quot[`OOO_XLEN-2:0], fits};
  end

  assign div_busy = (count != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count    <= '0;
      div_done <= 1'b0;
    end else begin
      // last step lands together with done
      div_done <= (count == CNT_W'(1));
      if (div_go) begin
        count <= CNT_W'(`OOO_DIV_STEPS);
      end else if (div_busy) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (div_go) begin
      quot     <= dispatch.a;
      divisor  <= dispatch.b;
      rem      <= '0;
      want_rem <= (dispatch.op == OP_REMU);
      tag      <= dispatch.tag;
    end else if (div_busy) begin
      quot <= quot_next;
      rem  <= rem_next;
    end
    // separate output register frees the core for the next divide
    if (count == CNT_W'(1)) begin
      div_result.tag    <= tag;
      div_result.result <= want_rem ? rem_next : quot_next;
    end
  end

  a_go_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    div_go |-> !div_busy)
    else $error("divide issued while divider busy");

endmodule

`default_nettype wire

// ==== hdl/fetch_decode_stage.sv ====
`default_nettype none

module fetch_decode_stage (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          instr_valid,
  input  logic [31:0]   instr,
  input  logic          stall_fetch_decode,
  output logic          instr_ready,
  output logic          uop_valid,
  output ooo_pkg::uop_t uop
);
  import ooo_pkg::*;

  uop_t dec;

  // decode straight from the incoming word, registered below
  always_comb begin
    dec           = '0;
    dec.op        = op_e'(instr[OP_LSB +: 4]);
    dec.rd        = instr[RD_LSB +: $bits(reg_idx_t)];
    dec.rs1       = instr[RS1_LSB +: $bits(reg_idx_t)];
    dec.rs2       = instr[RS2_LSB +: $bits(reg_idx_t)];
    // sign extend the 16-bit immediate
    dec.imm32     = {{($bits(word_t) - IMM_W){instr[IMM_W-1]}}, instr[IMM_W-1:0]};
    dec.fu        = ARITH_S;
    dec.src_a_sel = SRC_REG;
    dec.src_b_sel = SRC_REG;
    dec.wen       = 1'b1;
    dec.illegal   = 1'b0;
    case (dec.op)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
        dec.fu = ARITH_S;
      end
      OP_ADDI: begin
        dec.src_b_sel = SRC_IMM;
      end
      // lui reads no register at all
      OP_LUI: begin
        dec.src_a_sel = SRC_IMM;
        dec.src_b_sel = SRC_IMM;
      end
      OP_DIVU, OP_REMU: begin
        dec.fu = DIV_S;
      end
      default: begin
        // no sources and no write, so it never waits on the scoreboard
        dec.fu        = NONE_S;
        dec.src_a_sel = SRC_IMM;
        dec.src_b_sel = SRC_IMM;
        dec.wen       = 1'b0;
        dec.illegal   = 1'b1;
      end
    endcase
  end

  // full and held means no room for the next word
  assign instr_ready = ~(uop_valid & stall_fetch_decode);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      uop_valid <= 1'b0;
    end else if (instr_ready) begin
      uop_valid <= instr_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (instr_ready && instr_valid) begin
      uop <= dec;
    end
  end

  // a held uop must reach issue unchanged
  a_uop_stable: assert property (@(posedge clk) disable iff (!rst_n)
    uop_valid && stall_fetch_decode |=> uop_valid && $stable(uop))
    else $error("uop changed while held");

endmodule

`default_nettype wire

// ==== hdl/issue_stage.sv ====
`default_nettype none

`include "ooo_defs.svh"

module issue_stage (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               uop_valid,
  input  ooo_pkg::uop_t      uop,
  input  logic               stall_issue,
  input  ooo_pkg::tag_t      alloc_tag,
  input  logic               retire_valid,
  input  ooo_pkg::reg_idx_t  retire_rd,
  input  ooo_pkg::word_t     retire_data,
  output logic               rs1_busy,
  output logic               rs2_busy,
  output logic               rd_busy,
  output logic               alloc,
  output logic               arith_go,
  output logic               div_go,
  output ooo_pkg::dispatch_t dispatch
);
  import ooo_pkg::*;

  word_t                 regs [`OOO_NREGS];
  // one bit per register with a write still in flight
  logic [`OOO_NREGS-1:0] busy;
  logic                  issue;

  assign rs1_busy = busy[uop.rs1];
  assign rs2_busy = busy[uop.rs2];
  assign rd_busy  = busy[uop.rd];

  // every issued uop takes a buffer slot, illegal ones too
  assign issue    = uop_valid & ~stall_issue;
  assign alloc    = issue;
  assign arith_go = issue & (uop.fu == ARITH_S);
  assign div_go   = issue & (uop.fu == DIV_S);

  // operands come from committed state only
  always_comb begin
    dispatch.op  = uop.op;
    dispatch.a   = (uop.src_a_sel == SRC_IMM) ? uop.imm32 : regs[uop.rs1];
    dispatch.b   = (uop.src_b_sel == SRC_IMM) ? uop.imm32 : regs[uop.rs2];
    dispatch.tag = alloc_tag;
  end

  // architectural registers start at zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `OOO_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (retire_valid) begin
      regs[retire_rd] <= retire_data;
    end
  end

  // set after clear so a new writer wins on the same register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= '0;
    end else begin
      if (retire_valid) begin
        busy[retire_rd] <= 1'b0;
      end
      if (issue && uop.wen) begin
        busy[uop.rd] <= 1'b1;
      end
    end
  end

  a_no_busy_dispatch: assert property (@(posedge clk) disable iff (!rst_n)
    alloc |-> !(uop.wen && busy[uop.rd]) &&
              !(uop.src_a_sel == SRC_REG && busy[uop.rs1]) &&
              !(uop.src_b_sel == SRC_REG && busy[uop.rs2]))
    else $error("dispatch against a busy register");

  // same register on both sides only when an older write retires as a new one issues
  a_alloc_retire: assert property (@(posedge clk) disable iff (!rst_n)
    alloc && uop.wen && retire_valid && (retire_rd == uop.rd)
      |=> $past(busy[uop.rd]) && busy[$past(uop.rd)])
    else $error("alloc and retire collide on one register");

endmodule

`default_nettype wire

// ==== hdl/ooo_core.sv ====
`default_nettype none

module ooo_core (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             instr_valid,
  input  logic [31:0]      instr,
  output logic             instr_ready,
  output logic             commit_valid,
  output ooo_pkg::commit_t commit,
  input  logic             commit_ready
);
  import ooo_pkg::*;

  logic      uop_valid;
  uop_t      uop;
  logic      stall_issue;
  logic      stall_fetch_decode;
  logic      rs1_busy;
  logic      rs2_busy;
  logic      rd_busy;
  logic      alloc;
  tag_t      alloc_tag;
  logic      arith_go;
  logic      div_go;
  dispatch_t dispatch;
  logic      arith_done;
  complete_t arith_result;
  logic      div_busy;
  logic      div_done;
  complete_t div_result;
  logic      cb_full;
  logic      retire_valid;
  reg_idx_t  retire_rd;
  word_t     retire_data;

  fetch_decode_stage i_fetch_decode (
    .clk, .rst_n, .instr_valid, .instr, .stall_fetch_decode,
    .instr_ready, .uop_valid, .uop
  );

  ooo_hazard_unit i_hazard (
    .rs1_busy, .rs2_busy, .rd_busy,
    .src_a_sel (uop.src_a_sel),
    .src_b_sel (uop.src_b_sel),
    .wen       (uop.wen),
    .fu        (uop.fu),
    .uop_valid, .div_busy, .cb_full,
    .data_hazard (),
    .stall_issue, .stall_fetch_decode
  );

  issue_stage i_issue (
    .clk, .rst_n, .uop_valid, .uop, .stall_issue, .alloc_tag,
    .retire_valid, .retire_rd, .retire_data,
    .rs1_busy, .rs2_busy, .rd_busy, .alloc, .arith_go, .div_go, .dispatch
  );

  arith_unit i_arith (
    .clk, .rst_n, .arith_go, .dispatch, .arith_done, .arith_result
  );

  div_unit i_div (
    .clk, .rst_n, .div_go, .dispatch, .div_busy, .div_done, .div_result
  );

  // rd, wen and illegal ride along with the alloc pulse
  completion_buffer i_cb (
    .clk, .rst_n, .alloc,
    .alloc_rd      (uop.rd),
    .alloc_wen     (uop.wen),
    .alloc_illegal (uop.illegal),
    .arith_done, .arith_result, .div_done, .div_result, .commit_ready,
    .alloc_tag, .cb_full, .commit_valid, .commit,
    .retire_valid, .retire_rd, .retire_data
  );

endmodule

`default_nettype wire

// ==== hdl/ooo_defs.svh ====
`ifndef OOO_DEFS_SVH
`define OOO_DEFS_SVH

// datapath and register width
`define OOO_XLEN 32

// architectural register file
`define OOO_NREGS 8
// index width for eight registers
`define OOO_REG_W 3

// completion buffer entries, power of two so the pointers wrap freely
`define OOO_CB_DEPTH 4
// tag width follows the depth
`define OOO_TAG_W 2

// one quotient bit per divider iteration
`define OOO_DIV_STEPS 32

`endif

// ==== hdl/ooo_hazard_unit.sv ====
`default_nettype none

module ooo_hazard_unit (
  input  logic              rs1_busy,
  input  logic              rs2_busy,
  input  logic              rd_busy,
  input  ooo_pkg::src_sel_e src_a_sel,
  input  ooo_pkg::src_sel_e src_b_sel,
  input  logic              wen,
  input  ooo_pkg::fu_e      fu,
  input  logic              uop_valid,
  input  logic              div_busy,
  input  logic              cb_full,
  output logic              data_hazard,
  output logic              stall_issue,
  output logic              stall_fetch_decode
);
  import ooo_pkg::*;

  logic rs1_wait;
  logic rs2_wait;
  logic rd_wait;
  logic structural_hazard;

  // an immediate operand never waits on the scoreboard
  always_comb begin
    case (src_a_sel)
      SRC_REG: rs1_wait = rs1_busy;
      default: rs1_wait = 1'b0;
    endcase
  end

  always_comb begin
    case (src_b_sel)
      SRC_REG: rs2_wait = rs2_busy;
      default: rs2_wait = 1'b0;
    endcase
  end

  // waw, the pending write must commit first
  assign rd_wait = rd_busy & wen;

  assign data_hazard = rs1_wait | rs2_wait | rd_wait;

  // only one divide in flight, the alu is always free
  assign structural_hazard = (fu == DIV_S) & div_busy;

  // no uop, nothing to hold
  assign stall_issue = uop_valid & (data_hazard | structural_hazard | cb_full);

  // decode holds its uop exactly when issue cannot take it
  assign stall_fetch_decode = stall_issue;

endmodule

`default_nettype wire

// ==== hdl/ooo_pkg.sv ====
`default_nettype none

`include "ooo_defs.svh"

package ooo_pkg;

  typedef logic [`OOO_XLEN-1:0]  word_t;
  typedef logic [`OOO_REG_W-1:0] reg_idx_t;
  typedef logic [`OOO_TAG_W-1:0] tag_t;

  // instruction word layout
  // op[31:28] rd[27:25] rs1[24:22] rs2[21:19] imm[15:0]
  localparam int OP_LSB  = 28;
  localparam int RD_LSB  = 25;
  localparam int RS1_LSB = 22;
  localparam int RS2_LSB = 19;
  localparam int IMM_W   = 16;

  // codes 4'h9 to 4'hf are illegal
  typedef enum logic [3:0] {
    OP_ADD  = 4'h0,
    OP_SUB  = 4'h1,
    OP_AND  = 4'h2,
    OP_OR   = 4'h3,
    OP_XOR  = 4'h4,
    OP_ADDI = 4'h5,
    OP_LUI  = 4'h6,
    OP_DIVU = 4'h7,
    OP_REMU = 4'h8
  } op_e;

  // NONE_S marks an illegal uop, which never reaches a unit
  typedef enum logic [1:0] {
    ARITH_S = 2'd0,
    DIV_S   = 2'd1,
    NONE_S  = 2'd2
  } fu_e;

  typedef enum logic {
    SRC_REG = 1'b0,
    SRC_IMM = 1'b1
  } src_sel_e;

  typedef struct packed {
    op_e      op;
    fu_e      fu;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    src_sel_e src_a_sel;
    src_sel_e src_b_sel;
    logic     wen;
    logic     illegal;
    word_t    imm32;
  } uop_t;

  typedef struct packed {
    op_e   op;
    word_t a;
    word_t b;
    tag_t  tag;
  } dispatch_t;

  typedef struct packed {
    tag_t  tag;
    word_t result;
  } complete_t;

  typedef struct packed {
    reg_idx_t rd;
    logic     wen;
    logic     exc;
    word_t    data;
  } commit_t;

endpackage

`default_nettype wire

// ==== project.f ====
+incdir+hdl
hdl/ooo_pkg.sv
hdl/fetch_decode_stage.sv
hdl/ooo_hazard_unit.sv
hdl/issue_stage.sv
hdl/arith_unit.sv
hdl/div_unit.sv
hdl/completion_buffer.sv
hdl/ooo_core.sv
verification/ooo_core_tb.sv

// ==== verification/ooo_core_tb.sv ====
`default_nettype none

`include "ooo_defs.svh"

module ooo_core_tb;
  import ooo_pkg::*;

  localparam int RESET_CYCLES     = 16;
  localparam int HOLD_LEN         = 40;
  localparam int CYCLES_PER_INSTR = 200;

  logic        clk;
  logic        rst_n;
  logic        instr_valid;
  logic [31:0] instr;
  logic        instr_ready;
  logic        commit_valid;
  commit_t     commit;
  logic        commit_ready;

  // program words and the commits the in-order model expects from them
  logic [31:0] program_q [$];
  commit_t     expect_q [$];
  word_t       model_regs [`OOO_NREGS];

  int      value_errors;
  int      other_errors;
  int      commit_count;
  int      cycles;
  int      cycle_limit;
  int      bp_start;
  logic    hold_phase;
  logic    saw_backpressure;
  logic    held;
  commit_t held_commit;
  logic    post_reset_checked;

  ooo_core i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .instr_ready  (instr_ready),
    .commit_valid (commit_valid),
    .commit       (commit),
    .commit_ready (commit_ready)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50;
      clk = ~clk;
    end
  end

  task automatic check_field(string name, logic [63:0] expected, logic [63:0] actual);
    assert (actual == expected) else begin
      value_errors++;
      $display("** Error at %0t: %s expected %0h got %0h", $time, name, expected, actual);
    end
  endtask

  task automatic report_problem(string what);
    other_errors++;
    $display("Error at %0t: %s", $time, what);
  endtask

  task automatic print_counts();
    $display("%0d value errors, %0d other errors, %0d of %0d commits checked",
             value_errors, other_errors, commit_count, program_q.size());
  endtask

  // op[31:28] rd[27:25] rs1[24:22] rs2[21:19] imm[15:0]
  function automatic logic [31:0] encode(logic [3:0] op, int rd, int rs1, int rs2, int imm);
    return {op, rd[2:0], rs1[2:0], rs2[2:0], 3'b000, imm[15:0]};
  endfunction

  // in-order reference, one step per instruction
  task automatic push_instr(logic [31:0] word);
    logic [3:0] op;
    word_t      a;
    word_t      b;
    word_t      imm;
    word_t      res;
    logic       illegal;
    commit_t    exp;
    op      = word[31:28];
    a       = model_regs[word[24:22]];
    b       = model_regs[word[21:19]];
    imm     = {{16{word[15]}}, word[15:0]};
    res     = '0;
    illegal = 1'b0;
    case (op)
      OP_ADD:  res = a + b;
      OP_SUB:  res = a - b;
      OP_AND:  res = a & b;
      OP_OR:   res = a | b;
      OP_XOR:  res = a ^ b;
      OP_ADDI: res = a + imm;
      OP_LUI:  res = {word[15:0], 16'h0000};
      // zero divisor gives all ones and the dividend back
      OP_DIVU: res = (b == '0) ? '1 : a / b;
      OP_REMU: res = (b == '0) ? a : a % b;
      default: illegal = 1'b1;
    endcase
    exp.rd   = word[27:25];
    exp.wen  = ~illegal;
    exp.exc  = illegal;
    exp.data = res;
    if (!illegal) begin
      model_regs[word[27:25]] = res;
    end
    program_q.push_back(word);
    expect_q.push_back(exp);
  endtask

  // random 32-bit value through lui then addi
  task automatic load_random(int rd);
    push_instr(encode(OP_LUI, rd, 0, 0, int'($urandom)));
    push_instr(encode(OP_ADDI, rd, rd, 0, int'($urandom)));
  endtask

  task automatic build_program();
    for (int r = 0; r < `OOO_NREGS; r++) begin
      model_regs[r] = '0;
    end
    // r0 is never written, it serves as a zero divisor
    for (int r = 1; r <= 6; r++) begin
      load_random(r);
    end
    // long divides with independent alu ops that finish first
    push_instr(encode(OP_DIVU, 7, 1, 2, 0));
    push_instr(encode(OP_ADD, 3, 4, 5, 0));
    push_instr(encode(OP_REMU, 6, 1, 2, 0));
    push_instr(encode(OP_XOR, 5, 3, 4, 0));
    push_instr(encode(OP_DIVU, 4, 1, 0, 0));
    push_instr(encode(OP_REMU, 5, 2, 0, 0));
    push_instr(encode(OP_ADDI, 1, 0, 0, 100));
    push_instr(encode(OP_ADDI, 2, 0, 0, 7));
    push_instr(encode(OP_DIVU, 3, 1, 2, 0));
    push_instr(encode(OP_REMU, 4, 1, 2, 0));
    // raw chain, then waw through r5
    push_instr(encode(OP_ADD, 1, 1, 2, 0));
    push_instr(encode(OP_SUB, 2, 1, 3, 0));
    push_instr(encode(OP_AND, 3, 2, 1, 0));
    push_instr(encode(OP_OR, 4, 3, 2, 0));
    push_instr(encode(OP_DIVU, 5, 4, 2, 0));
    push_instr(encode(OP_ADD, 5, 5, 1, 0));
    push_instr(encode(OP_ADDI, 5, 5, 0, -3));
    // illegal codes, the reads after them must see the old rd
    push_instr(encode(4'hb, 6, 1, 2, 'h1234));
    push_instr(encode(OP_ADD, 7, 6, 0, 0));
    push_instr(encode(4'hf, 2, 0, 0, 0));
    push_instr(encode(OP_OR, 3, 2, 2, 0));
    // second divide waits on the busy divider
    push_instr(encode(OP_DIVU, 1, 7, 3, 0));
    push_instr(encode(OP_REMU, 2, 5, 4, 0));
    // commits are held from here, the buffer has to fill up
    bp_start = program_q.size();
    for (int r = 1; r < `OOO_NREGS; r++) begin
      push_instr(encode(OP_ADDI, r, 0, 0, int'($urandom)));
    end
    push_instr(encode(OP_ADD, 1, 2, 3, 0));
    push_instr(encode(OP_SUB, 4, 5, 6, 0));
    push_instr(encode(OP_XOR, 7, 1, 4, 0));
    cycle_limit = CYCLES_PER_INSTR * program_q.size() + RESET_CYCLES;
  endtask

  initial begin
    logic took;
    int   idx;
    int   hold_cycles;
    logic bp_done;
    void'($urandom(32'h948280b3));
    rst_n              = 1'b0;
    instr_valid        = 1'b0;
    instr              = '0;
    commit_ready       = 1'b0;
    value_errors       = 0;
    other_errors       = 0;
    commit_count       = 0;
    hold_phase         = 1'b0;
    saw_backpressure   = 1'b0;
    held               = 1'b0;
    post_reset_checked = 1'b0;
    build_program();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n       = 1'b1;
    idx         = 0;
    hold_cycles = 0;
    bp_done     = 1'b0;
    while (commit_count < program_q.size()) begin
      // transfer decided by the values in front of the coming edge
      @(negedge clk);
      took = instr_valid & instr_ready;
      @(posedge clk);
      #1;
      if (took) begin
        idx++;
        instr_valid = 1'b0;
      end
      if (!bp_done && idx >= bp_start) begin
        hold_cycles++;
        bp_done = (hold_cycles >= HOLD_LEN);
      end
      hold_phase   = !bp_done && (idx >= bp_start);
      commit_ready = !hold_phase && ($urandom_range(3) != 0);
      // valid only rises here, it falls after a transfer
      if (idx < program_q.size() && !instr_valid &&
          (hold_phase || $urandom_range(2) != 0)) begin
        instr_valid = 1'b1;
        instr       = program_q[idx];
      end
    end
    instr_valid  = 1'b0;
    commit_ready = 1'b1;
    // idle tail, any further commit is a duplicate
    repeat (20) @(posedge clk);
    #1;
    assert (saw_backpressure) else report_problem("instr_ready never dropped while commits held");
    print_counts();
    if (value_errors == 0 && other_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // outputs are settled at the falling edge
  always @(negedge clk) begin
    commit_t exp;
    if (!rst_n || !post_reset_checked) begin
      check_field("commit_valid", 64'(1'b0), 64'(commit_valid));
      check_field("instr_ready", 64'(1'b1), 64'(instr_ready));
      post_reset_checked = rst_n;
    end
    if (rst_n) begin
      // a stalled commit keeps valid and data
      if (held) begin
        check_field("commit_valid", 64'(1'b1), 64'(commit_valid));
        check_field("commit", 64'(held_commit), 64'(commit));
      end
      if (commit_valid && commit_ready) begin
        assert (expect_q.size() != 0) else report_problem("commit with nothing outstanding");
        if (expect_q.size() != 0) begin
          exp = expect_q.pop_front();
          check_field("commit.rd", 64'(exp.rd), 64'(commit.rd));
          check_field("commit.wen", 64'(exp.wen), 64'(commit.wen));
          check_field("commit.exc", 64'(exp.exc), 64'(commit.exc));
          // exceptions carry no result
          if (!exp.exc) begin
            check_field("commit.data", 64'(exp.data), 64'(commit.data));
          end
          commit_count++;
        end
      end
      if (hold_phase && instr_valid && !instr_ready) begin
        saw_backpressure = 1'b1;
      end
      held        = commit_valid & ~commit_ready;
      held_commit = commit;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      $display("timeout after %0d cycles, commits stopped arriving", cycles);
      print_counts();
      $display("sim failed");
      $finish;
    end
  end

endmodule

`default_nettype wire
